/* list.f */
+incdir+rtl
rtl/fp_host_pkg.sv
rtl/fp_log_pkg.sv
rtl/fp_endpoint_decoder.sv
rtl/osf_averager.sv
rtl/log_capture.sv
rtl/pipe_tx_fifo.sv
rtl/frontpanel_top.sv
tests/fp_checker.sv
tests/tb_frontpanel.sv

/* rtl/fp_defines.svh */
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Log channel count and widths
`define FP_N_LOG        8
`define FP_W_LCHAN      3
`define FP_W_LDATA      18
`define FP_W_EP         16
`define FP_W_RATIO      3

// Pipe FIFO size, any power of two
`define FP_FIFO_DEPTH   16
`define FP_W_FCOUNT     ($clog2(`FP_FIFO_DEPTH) + 1)

// Host endpoint addresses
`define FP_EP_ADDR      8'h00
`define FP_EP_CHAN      8'h01
`define FP_EP_DATA0     8'h02
`define FP_EP_DATA1     8'h03
`define FP_EP_DATA2     8'h04
`define FP_EP_DATA3     8'h05
`define FP_EP_LOG0      8'h20
`define FP_EP_PIPE_STAT 8'h30
`define FP_EP_TRIG      8'h40
`define FP_EP_PIPE      8'ha0

// Bit positions inside the trigger word
`define FP_TRIG_SYS_RST    0
`define FP_TRIG_ADC_CSTART 1
`define FP_TRIG_WR_EN      2
`define FP_TRIG_DAC_RSET   3

// Request codes carried in the address wire-in
`define FP_RQST_OSF_RATIO 16'h0001
`define FP_RQST_PIPE_CSET 16'h0002

`endif

/* rtl/fp_endpoint_decoder.sv */
`timescale 1ns/1ps

`include "fp_defines.svh"

module fp_endpoint_decoder (
    input  logic                                  sys_clk_in,
    input  logic                                  por_in,
    input  fp_host_pkg::host_req_t                host_req,
    input  logic [`FP_N_LOG-1:0][`FP_W_EP-1:0]    log_word,
    input  logic [`FP_W_EP-1:0]                   pipe_word,
    input  logic [`FP_W_FCOUNT-1:0]               pipe_count,
    output fp_host_pkg::host_rsp_t                host_rsp,
    output logic                                  sys_rst_out,
    output logic                                  adc_cstart_out,
    output logic                                  dac_rset_out,
    output fp_log_pkg::cfg_wr_t                   cfg_wr,
    output logic                                  pipe_pop
);
    import fp_host_pkg::*;
    import fp_log_pkg::*;

    // Wire-in registers
    logic [`FP_W_EP-1:0]        addr_q;
    logic [`FP_W_EP-1:0]        chan_q;
    logic [3:0][`FP_W_EP-1:0]   data_q;

    // Trigger pulses
    logic                       trig_wr;
    logic                       sys_rst_q;
    logic                       cstart_q;
    logic                       wr_en_q;
    logic                       dac_rset_q;

    // Read path
    logic [7:0]                 log_off;
    logic [`FP_W_EP-1:0]        rdata_d;
    host_rsp_t                  rsp_q;

    // ------------------------------------------------------------------
    // Triggers and reset
    // ------------------------------------------------------------------
    assign trig_wr = host_req.wr && (host_req.addr == `FP_EP_TRIG);

    // Registered reset from power-on or the trigger bit
    always_ff @(posedge sys_clk_in) begin
        sys_rst_q <= por_in | (trig_wr & host_req.wdata[`FP_TRIG_SYS_RST]);
    end

    // One-cycle pulses after the strobe
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            cstart_q   <= 1'b0;
            wr_en_q    <= 1'b0;
            dac_rset_q <= 1'b0;
        end else begin
            cstart_q   <= trig_wr & host_req.wdata[`FP_TRIG_ADC_CSTART];
            wr_en_q    <= trig_wr & host_req.wdata[`FP_TRIG_WR_EN];
            dac_rset_q <= trig_wr & host_req.wdata[`FP_TRIG_DAC_RSET];
        end
    end

    assign sys_rst_out    = sys_rst_q;
    assign adc_cstart_out = cstart_q;
    assign dac_rset_out   = dac_rset_q;

    // ------------------------------------------------------------------
    // Wire-ins and configuration write
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            addr_q <= '0;
            chan_q <= '0;
            data_q <= '0;
        end else if (host_req.wr) begin
            case (host_req.addr)
                `FP_EP_ADDR:  addr_q    <= host_req.wdata;
                `FP_EP_CHAN:  chan_q    <= host_req.wdata;
                `FP_EP_DATA0: data_q[0] <= host_req.wdata;
                `FP_EP_DATA1: data_q[1] <= host_req.wdata;
                `FP_EP_DATA2: data_q[2] <= host_req.wdata;
                `FP_EP_DATA3: data_q[3] <= host_req.wdata;
                default: ;
            endcase
        end
    end

    // Current wire-ins travel with the write-enable pulse
    assign cfg_wr.en   = wr_en_q;
    assign cfg_wr.addr = addr_q;
    assign cfg_wr.chan = chan_q;
    assign cfg_wr.data = data_q;

    // ------------------------------------------------------------------
    // Read-back
    // ------------------------------------------------------------------
    assign log_off = host_req.addr - `FP_EP_LOG0;

    always_comb begin
        rdata_d  = '0;
        pipe_pop = 1'b0;
        case (host_req.addr)
            `FP_EP_ADDR:  rdata_d = addr_q;
            `FP_EP_CHAN:  rdata_d = chan_q;
            `FP_EP_DATA0: rdata_d = data_q[0];
            `FP_EP_DATA1: rdata_d = data_q[1];
            `FP_EP_DATA2: rdata_d = data_q[2];
            `FP_EP_DATA3: rdata_d = data_q[3];
            `FP_EP_PIPE: begin
                // Empty pipe reads as zero
                pipe_pop = host_req.rd;
                rdata_d  = (pipe_count != '0) ? pipe_word : '0;
            end
            `FP_EP_PIPE_STAT: rdata_d = `FP_W_EP'(pipe_count);
            default: begin
                // Log wire-out window
                if (log_off < `FP_N_LOG) begin
                    rdata_d = log_word[log_off[`FP_W_LCHAN-1:0]];
                end
            end
        endcase
    end

    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            rsp_q <= '0;
        end else begin
            rsp_q.rvalid <= host_req.rd;
            rsp_q.rdata  <= host_req.rd ? rdata_d : '0;
        end
    end

    assign host_rsp = rsp_q;

    // A read comes as a lone strobe and is answered on the next edge
    a_rd_rvalid : assert property (@(posedge sys_clk_in) disable iff (sys_rst_out)
        host_req.rd |=> host_rsp.rvalid && !$past(host_req.wr));

endmodule

/* rtl/fp_host_pkg.sv */
`include "fp_defines.svh"

package fp_host_pkg;

    // ------------------------------------------------------------------
    // Host endpoint bus
    // ------------------------------------------------------------------

    // One request per cycle, wr and rd never together
    typedef struct packed {
        logic                wr;
        logic                rd;
        logic [7:0]          addr;
        logic [`FP_W_EP-1:0] wdata;
    } host_req_t;

    // Read response, one cycle after rd
    typedef struct packed {
        logic                rvalid;
        logic [`FP_W_EP-1:0] rdata;
    } host_rsp_t;

endpackage

/* rtl/fp_log_pkg.sv */
`include "fp_defines.svh"

package fp_log_pkg;

    // ------------------------------------------------------------------
    // Sample streams
    // ------------------------------------------------------------------

    // Raw ADC strobe with channel tag
    typedef struct packed {
        logic                    dv;
        logic [`FP_W_LCHAN-1:0]  chan;
        logic [`FP_W_LDATA-1:0]  data;
    } adc_sample_t;

    // Averaged value, same layout
    typedef adc_sample_t log_sample_t;

    // Configuration write built from wire-ins
    typedef struct packed {
        logic                  en;
        logic [`FP_W_EP-1:0]   addr;
        logic [`FP_W_EP-1:0]   chan;
        logic [4*`FP_W_EP-1:0] data;
    } cfg_wr_t;

endpackage

/* rtl/frontpanel_top.sv */
`timescale 1ns/1ps

`include "fp_defines.svh"

module frontpanel_top (
    input  logic                      sys_clk_in,
    input  logic                      por_in,
    input  fp_host_pkg::host_req_t    host_req,
    input  fp_log_pkg::adc_sample_t   adc_sample,
    output fp_host_pkg::host_rsp_t    host_rsp,
    output logic                      sys_rst_out,
    output logic                      adc_cstart_out,
    output logic                      dac_rset_out
);
    import fp_log_pkg::*;

    // Configuration and log streams
    cfg_wr_t                              cfg_wr;
    log_sample_t                          log_sample;

    // Wire-out words
    logic [`FP_N_LOG-1:0][`FP_W_EP-1:0]   log_word;

    // Pipe path
    logic                                 push_valid;
    logic [`FP_W_EP-1:0]                  push_word;
    logic                                 pipe_pop;
    logic [`FP_W_EP-1:0]                  pipe_word;
    logic [`FP_W_FCOUNT-1:0]              pipe_count;

    // ------------------------------------------------------------------
    // Host side
    // ------------------------------------------------------------------
    fp_endpoint_decoder decoder_inst (
        .sys_clk_in     (sys_clk_in),
        .por_in         (por_in),
        .host_req       (host_req),
        .log_word       (log_word),
        .pipe_word      (pipe_word),
        .pipe_count     (pipe_count),
        .host_rsp       (host_rsp),
        .sys_rst_out    (sys_rst_out),
        .adc_cstart_out (adc_cstart_out),
        .dac_rset_out   (dac_rset_out),
        .cfg_wr         (cfg_wr),
        .pipe_pop       (pipe_pop)
    );

    // ------------------------------------------------------------------
    // Sample side
    // ------------------------------------------------------------------
    osf_averager averager_inst (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .cfg_wr      (cfg_wr),
        .adc_sample  (adc_sample),
        .log_sample  (log_sample)
    );

    log_capture capture_inst (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .cfg_wr      (cfg_wr),
        .log_sample  (log_sample),
        .log_word    (log_word),
        .push_valid  (push_valid),
        .push_word   (push_word)
    );

    // Pipe words for the host
    pipe_tx_fifo fifo_inst (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .push_valid  (push_valid),
        .push_word   (push_word),
        .pipe_pop    (pipe_pop),
        .pipe_word   (pipe_word),
        .pipe_count  (pipe_count)
    );

endmodule

/* rtl/log_capture.sv */
`timescale 1ns/1ps

`include "fp_defines.svh"

module log_capture (
    input  logic                                  sys_clk_in,
    input  logic                                  sys_rst_out,
    input  fp_log_pkg::cfg_wr_t                   cfg_wr,
    input  fp_log_pkg::log_sample_t               log_sample,
    output logic [`FP_N_LOG-1:0][`FP_W_EP-1:0]    log_word,
    output logic                                  push_valid,
    output logic [`FP_W_EP-1:0]                   push_word
);
    // Latest value per channel
    logic [`FP_N_LOG-1:0][`FP_W_LDATA-1:0] log_q;

    // Channel routed to the pipe
    logic [`FP_W_LCHAN-1:0]                pipe_chan_q;
    logic                                  cset_wr;

    // ------------------------------------------------------------------
    // Wire-out registers
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            log_q <= '0;
        end else if (log_sample.dv) begin
            log_q[log_sample.chan] <= log_sample.data;
        end
    end

    // Host sees the upper bits only
    always_comb begin
        for (int n = 0; n < `FP_N_LOG; n++) begin
            log_word[n] = log_q[n][`FP_W_LDATA-1 -: `FP_W_EP];
        end
    end

    // ------------------------------------------------------------------
    // Pipe channel select
    // ------------------------------------------------------------------
    assign cset_wr = cfg_wr.en && (cfg_wr.addr == `FP_RQST_PIPE_CSET) &&
                     (cfg_wr.chan < `FP_N_LOG);

    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            pipe_chan_q <= '0;
        end else if (cset_wr) begin
            pipe_chan_q <= cfg_wr.chan[`FP_W_LCHAN-1:0];
        end
    end

    // Matching samples go to the FIFO on the same edge as the wire-out
    assign push_valid = log_sample.dv && (log_sample.chan == pipe_chan_q);
    assign push_word  = log_sample.data[`FP_W_LDATA-1 -: `FP_W_EP];

endmodule

/* rtl/osf_averager.sv */
`timescale 1ns/1ps

`include "fp_defines.svh"

module osf_averager (
    input  logic                      sys_clk_in,
    input  logic                      sys_rst_out,
    input  fp_log_pkg::cfg_wr_t       cfg_wr,
    input  fp_log_pkg::adc_sample_t   adc_sample,
    output fp_log_pkg::log_sample_t   log_sample
);
    // Counter covers up to 2^7 samples and the sum grows by as many bits
    localparam int W_CNT = (1 << `FP_W_RATIO) - 1;
    localparam int W_ACC = `FP_W_LDATA + W_CNT;

    // Per-channel state
    logic [`FP_N_LOG-1:0][`FP_W_RATIO-1:0] ratio_q;
    logic [`FP_N_LOG-1:0][W_CNT-1:0]       cnt_q;
    logic [`FP_N_LOG-1:0][W_ACC-1:0]       acc_q;

    // Incoming sample path
    logic [`FP_W_LCHAN-1:0]                ch;
    logic [W_ACC-1:0]                      sum;
    logic [W_ACC-1:0]                      sum_shr;
    logic [W_CNT-1:0]                      cnt_last;
    logic                                  block_done;

    // Ratio write decode
    logic                                  ratio_wr;
    logic [`FP_W_LCHAN-1:0]                wr_ch;

    // ------------------------------------------------------------------
    // Block sum and average
    // ------------------------------------------------------------------
    assign ch       = adc_sample.chan;
    assign sum      = acc_q[ch] + W_ACC'(adc_sample.data);
    // Truncating average
    assign sum_shr  = sum >> ratio_q[ch];
    assign cnt_last = W_CNT'((1 << ratio_q[ch]) - 1);
    // Last sample of the block
    assign block_done = (cnt_q[ch] == cnt_last);

    assign ratio_wr = cfg_wr.en && (cfg_wr.addr == `FP_RQST_OSF_RATIO) &&
                      (cfg_wr.chan < `FP_N_LOG);
    assign wr_ch    = cfg_wr.chan[`FP_W_LCHAN-1:0];

    // ------------------------------------------------------------------
    // Accumulators and output register
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            ratio_q    <= '0;
            cnt_q      <= '0;
            acc_q      <= '0;
            log_sample <= '0;
        end else begin
            log_sample.dv <= 1'b0;
            if (adc_sample.dv) begin
                if (block_done) begin
                    // Emit and restart the channel
                    log_sample.dv   <= 1'b1;
                    log_sample.chan <= ch;
                    log_sample.data <= sum_shr[`FP_W_LDATA-1:0];
                    acc_q[ch]       <= '0;
                    cnt_q[ch]       <= '0;
                end else begin
                    acc_q[ch] <= sum;
                    cnt_q[ch] <= cnt_q[ch] + 1'b1;
                end
            end
            // Host ratio write wins over a sample on the same channel
            if (ratio_wr) begin
                ratio_q[wr_ch] <= cfg_wr.data[`FP_W_RATIO-1:0];
                cnt_q[wr_ch]   <= '0;
                acc_q[wr_ch]   <= '0;
            end
        end
    end

    // Sample tag is a known channel whenever the strobe is set
    a_chan_range : assert property (@(posedge sys_clk_in) disable iff (sys_rst_out)
        adc_sample.dv |-> !$isunknown(adc_sample.chan));

endmodule

/* rtl/pipe_tx_fifo.sv */
`timescale 1ns/1ps

`include "fp_defines.svh"

module pipe_tx_fifo (
    input  logic                         sys_clk_in,
    input  logic                         sys_rst_out,
    input  logic                         push_valid,
    input  logic [`FP_W_EP-1:0]          push_word,
    input  logic                         pipe_pop,
    output logic [`FP_W_EP-1:0]          pipe_word,
    output logic [`FP_W_FCOUNT-1:0]      pipe_count
);
    localparam int W_PTR = $clog2(`FP_FIFO_DEPTH);

    // Storage
    logic [`FP_W_EP-1:0]     mem_q [`FP_FIFO_DEPTH];

    // Pointers wrap naturally at a power of two
    logic [W_PTR-1:0]        wr_ptr_q;
    logic [W_PTR-1:0]        rd_ptr_q;
    logic [`FP_W_FCOUNT-1:0] count_q;

    logic                    full;
    logic                    push_ok;
    logic                    pop_ok;

    assign full    = (count_q == `FP_FIFO_DEPTH);
    // Pop on empty does nothing
    assign pop_ok  = pipe_pop && (count_q != '0);
    // Full FIFO still takes a word when one leaves
    assign push_ok = push_valid && (!full || pop_ok);

    // ------------------------------------------------------------------
    // Buffer and pointers
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_word;
        end
    end

    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + `FP_W_FCOUNT'(push_ok) - `FP_W_FCOUNT'(pop_ok);
        end
    end

    // Head word, shown as is
    assign pipe_word  = mem_q[rd_ptr_q];
    assign pipe_count = count_q;

    a_count_max : assert property (@(posedge sys_clk_in) disable iff (sys_rst_out)
        pipe_count <= `FP_FIFO_DEPTH);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then search the log for a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_frontpanel -f list.f \
        -o tb_frontpanel > build.log 2>&1 \
    && ./obj_dir/tb_frontpanel > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "STATUS: FAIL" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || echo "Simulation passed"

/* tests/fp_checker.sv */
`timescale 1ns/1ps

`include "fp_defines.svh"

module fp_checker (
    input  logic                      sys_clk_in,
    input  logic                      por_in,
    input  fp_host_pkg::host_req_t    host_req,
    input  fp_log_pkg::adc_sample_t   adc_sample,
    input  fp_host_pkg::host_rsp_t    host_rsp,
    input  logic                      sys_rst_out,
    input  logic                      adc_cstart_out,
    input  logic                      dac_rset_out,
    input  int                        test_id,
    output int                        value_errors,
    output int                        other_errors
);
    // Wire-in mirror
    logic [`FP_W_EP-1:0]    wi_addr;
    logic [`FP_W_EP-1:0]    wi_chan;
    logic [`FP_W_EP-1:0]    wi_data [4];

    // Per-channel averager model, raw samples of the open block
    int                     ratio [`FP_N_LOG];
    int                     blk_n [`FP_N_LOG];
    logic [`FP_W_LDATA-1:0] blk [`FP_N_LOG][128];
    logic [`FP_W_LDATA-1:0] log_val [`FP_N_LOG];

    // Pipe model
    int                     pipe_chan;
    logic [`FP_W_EP-1:0]    fifo_m [$];

    // Effects due one edge later
    logic                   cfg_pend;
    logic                   avg_dv;
    int                     avg_ch;
    logic [`FP_W_LDATA-1:0] avg_data;

    // Predicted outputs after the current edge
    logic                   exp_rst;
    logic                   exp_cstart;
    logic                   exp_dac;
    logic                   exp_rvalid;
    logic [`FP_W_EP-1:0]    exp_rdata;
    logic [7:0]             exp_addr;
    int                     edges;

    function automatic string test_name(input int id);
        case (id)
            1:       return "power_on_reset";
            2:       return "trigger_pulses";
            3:       return "oversample_ratio";
            4:       return "pipe_select";
            5:       return "pipe_overflow";
            default: return "startup";
        endcase
    endfunction

    // Block average: plain sum of the recorded samples over 2^ratio
    function automatic logic [`FP_W_LDATA-1:0] block_average(input int ch);
        logic [31:0] total;
        total = 32'd0;
        for (int i = 0; i < blk_n[ch]; i++) begin
            total = total + 32'(blk[ch][i]);
        end
        return `FP_W_LDATA'(total / (32'd1 << ratio[ch]));
    endfunction

    // Read-back value from the model state before the edge
    function automatic logic [`FP_W_EP-1:0] read_value(input logic [7:0] a);
        logic [`FP_W_EP-1:0] v;
        v = '0;
        if (a >= `FP_EP_LOG0 && a < `FP_EP_LOG0 + `FP_N_LOG) begin
            v = log_val[int'(a - `FP_EP_LOG0)][`FP_W_LDATA-1 -: `FP_W_EP];
        end else begin
            case (a)
                `FP_EP_ADDR:      v = wi_addr;
                `FP_EP_CHAN:      v = wi_chan;
                `FP_EP_DATA0:     v = wi_data[0];
                `FP_EP_DATA1:     v = wi_data[1];
                `FP_EP_DATA2:     v = wi_data[2];
                `FP_EP_DATA3:     v = wi_data[3];
                `FP_EP_PIPE:      v = (fifo_m.size() > 0) ? fifo_m[0] : '0;
                `FP_EP_PIPE_STAT: v = `FP_W_EP'(fifo_m.size());
                default:          v = '0;
            endcase
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            value_errors++;
            $display("error: test %s, %s: expected %0h, actual %0h",
                     test_name(test_id), what, exp_v, act_v);
        end
    endtask

    initial begin
        value_errors = 0;
        other_errors = 0;
        edges        = 0;
        cfg_pend     = 1'b0;
        avg_dv       = 1'b0;
        pipe_chan    = 0;
        for (int n = 0; n < `FP_N_LOG; n++) begin
            ratio[n]   = 0;
            blk_n[n]   = 0;
            log_val[n] = '0;
        end
    end

    // ------------------------------------------------------------------
    // Compare last prediction, then step the model
    // ------------------------------------------------------------------
    always @(posedge sys_clk_in) begin : model_step
        logic                   trig;
        logic                   new_dv;
        int                     new_ch;
        logic [`FP_W_LDATA-1:0] new_data;
        int                     ch;
        int                     wc;

        edges++;
        if (edges > 1) begin
            check_value("sys_rst_out", 32'(exp_rst), 32'(sys_rst_out));
            check_value("adc_cstart_out", 32'(exp_cstart), 32'(adc_cstart_out));
            check_value("dac_rset_out", 32'(exp_dac), 32'(dac_rset_out));
            if (host_rsp.rvalid !== exp_rvalid) begin
                other_errors++;
                if (exp_rvalid) begin
                    $display("read of endpoint %02h got no response", exp_addr);
                end else begin
                    $display("read response appeared without a read");
                end
            end else if (exp_rvalid) begin
                check_value($sformatf("read of endpoint %02h", exp_addr),
                            32'(exp_rdata), 32'(host_rsp.rdata));
            end
        end

        trig    = host_req.wr && (host_req.addr == `FP_EP_TRIG);
        exp_rst = por_in | (trig & host_req.wdata[`FP_TRIG_SYS_RST]);
        new_dv  = 1'b0;
        new_ch  = 0;
        new_data = '0;

        if (sys_rst_out === 1'b1) begin
            // Everything back to zero
            exp_cstart = 1'b0;
            exp_dac    = 1'b0;
            exp_rvalid = 1'b0;
            exp_rdata  = '0;
            wi_addr    = '0;
            wi_chan    = '0;
            for (int i = 0; i < 4; i++) begin
                wi_data[i] = '0;
            end
            for (int n = 0; n < `FP_N_LOG; n++) begin
                ratio[n]   = 0;
                blk_n[n]   = 0;
                log_val[n] = '0;
            end
            pipe_chan = 0;
            fifo_m.delete();
            cfg_pend = 1'b0;
        end else begin
            // Read response from state before the edge
            exp_rvalid = host_req.rd;
            exp_addr   = host_req.addr;
            exp_rdata  = host_req.rd ? read_value(host_req.addr) : '0;
            exp_cstart = trig & host_req.wdata[`FP_TRIG_ADC_CSTART];
            exp_dac    = trig & host_req.wdata[`FP_TRIG_DAC_RSET];

            // Pop first, so a full FIFO takes a word on a read
            if (host_req.rd && host_req.addr == `FP_EP_PIPE && fifo_m.size() > 0) begin
                void'(fifo_m.pop_front());
            end
            if (avg_dv && avg_ch == pipe_chan && fifo_m.size() < `FP_FIFO_DEPTH) begin
                fifo_m.push_back(avg_data[`FP_W_LDATA-1 -: `FP_W_EP]);
            end
            if (avg_dv) begin
                log_val[avg_ch] = avg_data;
            end

            // Record the sample, close the block at 2^ratio
            if (adc_sample.dv) begin
                ch = int'(adc_sample.chan);
                blk[ch][blk_n[ch]] = adc_sample.data;
                blk_n[ch]++;
                if (blk_n[ch] == (1 << ratio[ch])) begin
                    new_dv   = 1'b1;
                    new_ch   = ch;
                    new_data = block_average(ch);
                    blk_n[ch] = 0;
                end
            end

            // Configuration write with the wire-ins of the trigger
            if (cfg_pend && wi_chan < `FP_N_LOG) begin
                wc = int'(wi_chan);
                if (wi_addr == `FP_RQST_OSF_RATIO) begin
                    ratio[wc] = int'(wi_data[0][`FP_W_RATIO-1:0]);
                    blk_n[wc] = 0;
                end
                if (wi_addr == `FP_RQST_PIPE_CSET) begin
                    pipe_chan = wc;
                end
            end

            if (host_req.wr) begin
                case (host_req.addr)
                    `FP_EP_ADDR:  wi_addr    = host_req.wdata;
                    `FP_EP_CHAN:  wi_chan    = host_req.wdata;
                    `FP_EP_DATA0: wi_data[0] = host_req.wdata;
                    `FP_EP_DATA1: wi_data[1] = host_req.wdata;
                    `FP_EP_DATA2: wi_data[2] = host_req.wdata;
                    `FP_EP_DATA3: wi_data[3] = host_req.wdata;
                    default: ;
                endcase
            end
            cfg_pend = trig & host_req.wdata[`FP_TRIG_WR_EN];
        end

        avg_dv   = new_dv;
        avg_ch   = new_ch;
        avg_data = new_data;
    end

endmodule

/* tests/tb_frontpanel.sv */
`timescale 1ns/1ps

`include "fp_defines.svh"

module tb_frontpanel;
    import fp_host_pkg::*;
    import fp_log_pkg::*;

    // DUT ports
    logic        sys_clk_in;
    logic        por_in;
    host_req_t   host_req;
    adc_sample_t adc_sample;
    host_rsp_t   host_rsp;
    logic        sys_rst_out;
    logic        adc_cstart_out;
    logic        dac_rset_out;

    // Run bookkeeping
    int          test_id;
    int          value_errors;
    int          other_errors;
    int          tb_errors;
    int          ops;
    int          cycles;
    logic [31:0] rng_state;

    frontpanel_top frontpanel_top_inst (
        .sys_clk_in     (sys_clk_in),
        .por_in         (por_in),
        .host_req       (host_req),
        .adc_sample     (adc_sample),
        .host_rsp       (host_rsp),
        .sys_rst_out    (sys_rst_out),
        .adc_cstart_out (adc_cstart_out),
        .dac_rset_out   (dac_rset_out)
    );

    fp_checker checker_inst (
        .sys_clk_in     (sys_clk_in),
        .por_in         (por_in),
        .host_req       (host_req),
        .adc_sample     (adc_sample),
        .host_rsp       (host_rsp),
        .sys_rst_out    (sys_rst_out),
        .adc_cstart_out (adc_cstart_out),
        .dac_rset_out   (dac_rset_out),
        .test_id        (test_id),
        .value_errors   (value_errors),
        .other_errors   (other_errors)
    );

    // 20 ns period
    initial sys_clk_in = 1'b0;
    always #10 sys_clk_in = ~sys_clk_in;

    // Limit grows with every operation issued
    always @(posedge sys_clk_in) begin
        cycles++;
        if (cycles > 40 * ops + 500) begin
            $display("timeout after %0d cycles, %0d operations issued", cycles, ops);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function logic [31:0] next_random();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // ------------------------------------------------------------------
    // Bus tasks, all entered 1 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge sys_clk_in);
            #1;
        end
        ops++;
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
        host_req.wr    = 1'b1;
        host_req.addr  = addr;
        host_req.wdata = data;
        @(posedge sys_clk_in);
        #1;
        host_req = '0;
        ops++;
    endtask

    task automatic bus_read(input logic [7:0] addr);
        int waited;
        host_req.rd   = 1'b1;
        host_req.addr = addr;
        @(posedge sys_clk_in);
        #1;
        host_req = '0;
        waited   = 0;
        // Response is due now; allow a few cycles before giving up
        while (!host_rsp.rvalid && waited < 4) begin
            @(posedge sys_clk_in);
            #1;
            waited++;
        end
        if (!host_rsp.rvalid) begin
            tb_errors++;
            $display("no read response for endpoint %02h", addr);
        end
        ops++;
    endtask

    task automatic read_logs();
        for (int n = 0; n < `FP_N_LOG; n++) begin
            bus_read(8'(`FP_EP_LOG0 + n));
        end
    endtask

    task automatic set_config(input logic [15:0] rqst, input logic [15:0] chan,
                              input logic [15:0] value);
        bus_write(`FP_EP_ADDR, rqst);
        bus_write(`FP_EP_CHAN, chan);
        bus_write(`FP_EP_DATA0, value);
        bus_write(`FP_EP_TRIG, 16'(1 << `FP_TRIG_WR_EN));
        wait_cycles(2);
    endtask

    // One sample per cycle on channels picked from the mask
    task automatic feed_random(input int n, input logic [7:0] chan_mask);
        logic [31:0] r;
        logic [2:0]  ch;
        for (int i = 0; i < n; i++) begin
            r  = next_random();
            ch = r[2:0];
            while (!chan_mask[ch]) begin
                r  = next_random();
                ch = r[2:0];
            end
            r = next_random();
            adc_sample.dv   = 1'b1;
            adc_sample.chan = ch;
            adc_sample.data = r[31:14];
            @(posedge sys_clk_in);
            #1;
            ops++;
        end
        adc_sample = '0;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        por_in     = 1'b1;
        host_req   = '0;
        adc_sample = '0;
        test_id    = 0;
        tb_errors  = 0;
        ops        = 0;
        cycles     = 0;
        rng_state  = 32'd54;
        repeat (16) @(posedge sys_clk_in);
        #1;
        por_in = 1'b0;
        wait_cycles(2);

        // Everything reads zero after power-on
        test_id = 1;
        read_logs();
        bus_read(`FP_EP_PIPE);
        bus_read(`FP_EP_PIPE_STAT);

        // Mixed trigger bits, then a soft reset
        test_id = 2;
        bus_write(`FP_EP_TRIG, 16'((1 << `FP_TRIG_ADC_CSTART) | (1 << `FP_TRIG_DAC_RSET)));
        wait_cycles(3);
        feed_random(16, 8'hff);
        wait_cycles(3);
        read_logs();
        bus_write(`FP_EP_TRIG, 16'(1 << `FP_TRIG_SYS_RST));
        wait_cycles(3);
        read_logs();

        // Ratios 0, 2 and 5 on three channels
        test_id = 3;
        set_config(`FP_RQST_OSF_RATIO, 16'd1, 16'd0);
        set_config(`FP_RQST_OSF_RATIO, 16'd3, 16'd2);
        set_config(`FP_RQST_OSF_RATIO, 16'd6, 16'd5);
        feed_random(100, 8'b0100_1010);
        wait_cycles(3);
        read_logs();
        feed_random(100, 8'b0100_1010);
        wait_cycles(3);
        read_logs();

        // Only channel 3 reaches the pipe
        test_id = 4;
        set_config(`FP_RQST_PIPE_CSET, 16'd3, 16'd0);
        feed_random(120, 8'b0100_1010);
        wait_cycles(3);
        bus_read(`FP_EP_PIPE_STAT);
        repeat (`FP_FIFO_DEPTH + 2) bus_read(`FP_EP_PIPE);

        // Overfill through channel 1, drain past empty
        test_id = 5;
        set_config(`FP_RQST_PIPE_CSET, 16'd1, 16'd0);
        feed_random(`FP_FIFO_DEPTH + 8, 8'b0000_0010);
        wait_cycles(3);
        bus_read(`FP_EP_PIPE_STAT);
        repeat (`FP_FIFO_DEPTH + 1) bus_read(`FP_EP_PIPE);
        bus_read(`FP_EP_PIPE_STAT);
        wait_cycles(4);

        $display("errors: value %0d, other %0d", value_errors, other_errors + tb_errors);
        if (value_errors == 0 && other_errors + tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
